//--- tb/fp_seq_assert.sv
`timescale 1ns/1ps

module fp_seq_assert (
	input logic              clk_sys,
	input logic              reset,
	input logic              strob1,
	input logic              strob1b,
	input logic              strob2,
	input logic              strob2b,
	input fp_pkg::fp_phase_t cur_phase,
	input logic              res_valid,
	input logic              res_ready,
	input fp_pkg::fp_res_t   res
);

	// ------------------------------------------------------------
	// Strobe phases
	// ------------------------------------------------------------

	// strob1 always gets its settle cycle
	a_st1_settle: assert property (@(posedge clk_sys) disable iff (reset)
		strob1 |=> strob1b)
		else $error("strob1 not followed by its settle phase");

	// strob2 only one settle cycle after strob1 of a two-step command
	// so the two strobes never meet
	a_st2_order: assert property (@(posedge clk_sys) disable iff (reset)
		strob2 |-> $past(strob1b && cur_phase.two_step))
		else $error("strob2 without a preceding two-step strob1");

	a_st2_settle: assert property (@(posedge clk_sys) disable iff (reset)
		strob2 |=> strob2b)
		else $error("strob2 not followed by its settle phase");

	// ------------------------------------------------------------
	// Result handshake
	// ------------------------------------------------------------

	// Offer held until taken
	a_valid_held: assert property (@(posedge clk_sys) disable iff (reset)
		res_valid && !res_ready |=> res_valid)
		else $error("res_valid dropped during a stall");

	// Data frozen while stalled
	a_res_stable: assert property (@(posedge clk_sys) disable iff (reset)
		res_valid && !res_ready |=> $stable(res))
		else $error("res changed during a stall");

	// Quiet right after reset
	a_reset_quiet: assert property (@(posedge clk_sys)
		reset |=> !res_valid)
		else $error("res_valid high in the cycle after reset");

endmodule

bind fp_seq_top fp_seq_assert u_assert (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.strob1    (strob1),
	.strob1b   (strob1b),
	.strob2    (strob2),
	.strob2b   (strob2b),
	.cur_phase (cur_phase),
	.res_valid (res_valid),
	.res_ready (res_ready),
	.res       (res)
);

//--- tb/fp_seq_tb.sv
`timescale 1ns/1ps

`include "fp_macros.svh"

module fp_seq_tb;

	import fp_pkg::*;

	localparam int CLK_PERIOD     = 8;	// ns
	localparam int RESET_CYC      = 8;
	localparam int TAB_LEN        = 27;
	localparam int STALL_HEAVY_AT = 10;	// Results from here on see stalls
	localparam int STALL_LIGHT_AT = 20;
	localparam int WATCHDOG_CYC   = TAB_LEN * 20 + RESET_CYC;

	// One table row with command, expected result and a clear in front
	typedef struct packed {
		logic    clr_before;
		fp_cmd_u cmd;
		fp_res_t want;
	} vec_t;

	logic    clk_sys = 1'b0;
	logic    reset;
	logic    clear;
	logic    cmd_valid;
	fp_cmd_u cmd;
	logic    res_ready;
	logic    cmd_ready;
	logic    res_valid;
	fp_res_t res;

	vec_t tab [TAB_LEN];
	int   rcv_idx;	// Results taken so far
	int   overlaps;	// Results delivered with the next command already pending

	fp_seq_top DUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.clear     (clear),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.res_ready (res_ready),
		.cmd_ready (cmd_ready),
		.res_valid (res_valid),
		.res       (res)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// Failure reporting and the compare task
	// ------------------------------------------------------------
	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("** Error @ %0t ns: %s: got 0x%0h, expected 0x%0h",
				$time, what, got, want);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------
	// Command encoders and the stimulus table
	// ------------------------------------------------------------
	function automatic fp_cmd_u enc_arith(input fp_op_e op,
			input logic [`FP_WIDTH-3:0] val);
		fp_cmd_u c;
		c.arith.op      = op;
		c.arith.operand = val;
		return c;
	endfunction

	function automatic fp_cmd_u enc_shift(input logic right, input logic [`FP_CNT_W-1:0] n);
		fp_cmd_u c;
		c = '0;	// Pad bits stay zero
		c.shift.op        = OP_SHIFT;
		c.shift.dir_right = right;
		c.shift.count     = n;
		return c;
	endfunction

	task automatic put_vec(input int idx, input logic clr, input fp_cmd_u c,
			input logic [`FP_WIDTH-1:0] val, input logic zero);
		tab[idx].clr_before = clr;
		tab[idx].cmd        = c;
		tab[idx].want.value = val;
		tab[idx].want.zero  = zero;
	endtask

	// Expected values worked out by hand from accumulator 0
	task automatic fill_table();
		put_vec(0,  0, enc_arith(OP_LOAD, 14'h1234), 16'h1234, 0);
		put_vec(1,  0, enc_shift(0, 4'd0),  16'h1234, 0);	// Count 0 holds
		put_vec(2,  0, enc_shift(0, 4'd4),  16'h2340, 0);
		put_vec(3,  0, enc_shift(1, 4'd0),  16'h2340, 0);
		put_vec(4,  0, enc_shift(1, 4'd8),  16'h0023, 0);
		put_vec(5,  0, enc_shift(0, 4'd15), 16'h8000, 0);	// Only bit 0 survives
		put_vec(6,  0, enc_shift(1, 4'd15), 16'h0001, 0);
		put_vec(7,  0, enc_shift(1, 4'd1),  16'h0000, 1);
		put_vec(8,  0, enc_arith(OP_LOAD, 14'h3fff), 16'h3fff, 0);
		put_vec(9,  0, enc_shift(0, 4'd2),  16'hfffc, 0);
		// Arithmetic section wrapping both ways
		put_vec(10, 0, enc_arith(OP_ADD, 14'h0004), 16'h0000, 1);	// Wrap to exactly 0
		put_vec(11, 0, enc_arith(OP_ADD, 14'h0005), 16'h0005, 0);
		put_vec(12, 0, enc_arith(OP_SUB, 14'h0007), 16'hfffe, 0);	// Below zero
		put_vec(13, 0, enc_arith(OP_ADD, 14'h0002), 16'h0000, 1);
		put_vec(14, 0, enc_arith(OP_ADD, 14'h3fff), 16'h3fff, 0);
		put_vec(15, 0, enc_arith(OP_ADD, 14'h3fff), 16'h7ffe, 0);
		put_vec(16, 0, enc_arith(OP_SUB, 14'h0001), 16'h7ffd, 0);
		put_vec(17, 0, enc_shift(1, 4'd3),  16'h0fff, 0);
		put_vec(18, 0, enc_arith(OP_SUB, 14'h0fff), 16'h0000, 1);
		put_vec(19, 0, enc_arith(OP_LOAD, 14'h1555), 16'h1555, 0);
		// Clear sections
		put_vec(20, 1, enc_arith(OP_ADD, 14'h0123), 16'h0123, 0);	// From zero
		put_vec(21, 0, enc_arith(OP_SUB, 14'h0124), 16'hffff, 0);
		put_vec(22, 0, enc_shift(0, 4'd1),  16'hfffe, 0);
		put_vec(23, 0, enc_arith(OP_ADD, 14'h0002), 16'h0000, 1);
		put_vec(24, 0, enc_arith(OP_LOAD, 14'h00ff), 16'h00ff, 0);
		put_vec(25, 1, enc_arith(OP_ADD, 14'h0010), 16'h0010, 0);
		put_vec(26, 0, enc_shift(1, 4'd4),  16'h0001, 0);
	endtask

	// ------------------------------------------------------------
	// Command side
	// ------------------------------------------------------------
	// Valid stays high from one command to the next
	task automatic send_cmd(input fp_cmd_u c);
		@(negedge clk_sys);
		cmd       = c;
		cmd_valid = 1'b1;
		while (!cmd_ready)
			@(negedge clk_sys);	// Transfer on the next rising edge
	endtask

	initial begin : driver
		int i;
		reset     = 1'b1;
		clear     = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		fill_table();
		repeat (RESET_CYC) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_value("res_valid after reset", res_valid, 1'b0);
		check_value("cmd_ready after reset", cmd_ready, 1'b1);
		for (i = 0; i < TAB_LEN; i++) begin
			if (tab[i].clr_before) begin
				@(negedge clk_sys);
				cmd_valid = 1'b0;
				wait (rcv_idx == i);	// Unit drained
				@(negedge clk_sys);
				clear = 1'b1;
				@(negedge clk_sys);
				clear = 1'b0;
			end
			send_cmd(tab[i].cmd);
		end
		@(negedge clk_sys);
		cmd_valid = 1'b0;
		wait (rcv_idx == TAB_LEN);
		repeat (10) @(negedge clk_sys);	// Room for a stray extra result
		check_value("two commands in flight at least once", overlaps != 0, 1'b1);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// ------------------------------------------------------------
	// Result side with random back-pressure by section
	// ------------------------------------------------------------
	function automatic logic pick_ready(input int idx);
		logic rdy;
		if (idx < STALL_HEAVY_AT)
			rdy = 1'b1;	// Full throughput
		else if (idx < STALL_LIGHT_AT)
			rdy = ($urandom % 2) == 0;	// About half the cycles stalled
		else
			rdy = ($urandom % 4) != 0;
		return rdy;
	endfunction

	initial begin : receiver
		res_ready = 1'b0;
		rcv_idx   = 0;
		overlaps  = 0;
		void'($urandom(32'h2b7a_368c));
		forever begin
			@(negedge clk_sys);
			res_ready = pick_ready(rcv_idx);
			if (res_valid && res_ready) begin
				if (rcv_idx >= TAB_LEN) begin
					$display("Result offered after every command was answered");
					abort_run();
				end else begin
					check_value($sformatf("vector %0d value", rcv_idx),
						res.value, tab[rcv_idx].want.value);
					check_value($sformatf("vector %0d zero flag", rcv_idx),
						res.zero, tab[rcv_idx].want.zero);
					if (!cmd_ready)
						overlaps++;	// Next command already pending
					rcv_idx++;
				end
			end
		end
	end

	// Watchdog sized from the table length
	initial begin : watchdog
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Watchdog fired after %0d cycles, the run hung", WATCHDOG_CYC);
		abort_run();
	end

endmodule

//--- verilog/fp_accum.sv
`timescale 1ns/1ps

`include "fp_macros.svh"

module fp_accum (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              clear,	// Wins over strobes
	input  logic              strob1,
	input  logic              strob2,
	input  fp_pkg::fp_cmd_u   cur_cmd,
	input  fp_pkg::fp_phase_t cur_phase,
	output fp_pkg::fp_res_t   res
);

	import fp_pkg::*;

	logic [`FP_WIDTH-1:0] acc;
	logic [`FP_WIDTH-1:0] opnd;	// Second operand for ADD/SUB
	logic [`FP_WIDTH-1:0] imm;	// Operand field, zero-extended
	logic [`FP_WIDTH-1:0] shifted;
	logic [`FP_WIDTH-1:0] sum;
	logic [`FP_CNT_W-1:0] cnt;

	assign imm = {2'b00, cur_cmd.arith.operand};
	assign cnt = cur_cmd.shift.count;

	// ------------------------------------------------------------
	// Combinational results
	// ------------------------------------------------------------

	// Logical shift, count 0 passes through
	always_comb begin
		if (cur_cmd.shift.dir_right)
			shifted = acc >> cnt;
		else
			shifted = acc << cnt;
	end

	// Wraps modulo 2^16
	always_comb begin
		if (cur_phase.op == OP_SUB)
			sum = acc - opnd;
		else
			sum = acc + opnd;
	end

	// ------------------------------------------------------------
	// Accumulator
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
		end else if (clear) begin
			acc <= '0;
		end else if (strob1) begin
			case (cur_phase.op)
				OP_LOAD:  acc <= imm;
				OP_SHIFT: acc <= shifted;
				default:  acc <= acc;	// ADD/SUB wait for strob2
			endcase
		end else if (strob2) begin
			acc <= sum;
		end
	end

	// Operand capture on the first strobe of a two-step op
	always_ff @(posedge clk_sys) begin
		if (strob1 & cur_phase.two_step)
			opnd <= imm;
	end

	// Result straight from the register
	assign res.value = acc;
	assign res.zero  = acc == '0;

endmodule

//--- verilog/fp_cmd_decode.sv
`timescale 1ns/1ps

module fp_cmd_decode (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             cmd_valid,
	input  fp_pkg::fp_cmd_u  cmd,
	input  logic             strob1,
	output logic             cmd_ready,
	output logic             pend_full,
	output fp_pkg::fp_phase_t cur_phase,
	output fp_pkg::fp_cmd_u  cur_cmd
);

	import fp_pkg::*;

	fp_cmd_u   pend_cmd;	// Waiting for strob1
	fp_cmd_u   exec_cmd;	// Owned by the datapath
	fp_phase_t pend_phase;
	fp_phase_t exec_phase;
	logic      take;

	// ------------------------------------------------------------
	// Opcode classification
	// ------------------------------------------------------------
	function automatic fp_phase_t classify(input fp_op_e op);
		fp_phase_t p;
		p.op = op;
		case (op)
			OP_ADD, OP_SUB: begin
				p.two_step = 1'b1;
				p.one_step = 1'b0;
			end
			default: begin	// LOAD and SHIFT
				p.two_step = 1'b0;
				p.one_step = 1'b1;
			end
		endcase
		return p;
	endfunction

	assign cmd_ready = ~pend_full;	// One slot only
	assign take = cmd_valid & cmd_ready;

	assign pend_phase = classify(pend_cmd.arith.op);

	// ------------------------------------------------------------
	// Pending slot
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset)
			pend_full <= 1'b0;
		else if (strob1)
			pend_full <= 1'b0;	// Handed to execution
		else if (take)
			pend_full <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (take)
			pend_cmd <= cmd;
	end

	// Executing slot, loaded at the end of strob1
	always_ff @(posedge clk_sys) begin
		if (strob1) begin
			exec_cmd   <= pend_cmd;
			exec_phase <= pend_phase;
		end
	end

	// During strob1 the incoming command is already visible
	// so the datapath acts on it in the same cycle
	assign cur_cmd   = strob1 ? pend_cmd : exec_cmd;
	assign cur_phase = strob1 ? pend_phase : exec_phase;

endmodule

//--- verilog/fp_macros.svh
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------

// Command word, accumulator and result value
`define FP_WIDTH 16

// Shift count field
`define FP_CNT_W 4

`endif

//--- verilog/fp_pkg.sv
`include "fp_macros.svh"

package fp_pkg;

	// Opcode in the top two bits of every command
	typedef enum logic [1:0] {
		OP_LOAD  = 2'd0,	// One strobe
		OP_SHIFT = 2'd1,	// One strobe
		OP_ADD   = 2'd2,	// Two strobes
		OP_SUB   = 2'd3	// Two strobes
	} fp_op_e;

	// ------------------------------------------------------------
	// Command word and its two decodings
	// ------------------------------------------------------------
	typedef struct packed {
		fp_op_e                 op;
		logic [`FP_WIDTH-3:0]   operand;	// Zero-extended on use
	} fp_arith_t;

	typedef struct packed {
		fp_op_e                          op;
		logic                            dir_right;	// 1 = right
		logic [`FP_WIDTH-4-`FP_CNT_W:0]  pad;
		logic [`FP_CNT_W-1:0]            count;
	} fp_shift_t;

	typedef union packed {
		fp_arith_t arith;
		fp_shift_t shift;
	} fp_cmd_u;

	// Strobe classification, the old dp lines
	typedef struct packed {
		logic   two_step;	// Needs strob2
		logic   one_step;	// Done after strob1
		fp_op_e op;
	} fp_phase_t;

	// Result word
	typedef struct packed {
		logic [`FP_WIDTH-1:0] value;
		logic                 zero;
	} fp_res_t;

endpackage

//--- verilog/fp_seq_top.sv
`timescale 1ns/1ps

module fp_seq_top (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            clear,
	input  logic            cmd_valid,
	input  fp_pkg::fp_cmd_u cmd,
	input  logic            res_ready,
	output logic            cmd_ready,
	output logic            res_valid,
	output fp_pkg::fp_res_t res
);

	import fp_pkg::*;

	// ------------------------------------------------------------
	// Internal nets
	// ------------------------------------------------------------
	logic      pend_full;	// es1
	fp_phase_t cur_phase;
	fp_cmd_u   cur_cmd;
	logic      strob1;
	logic      strob1b;	// Settling phases, watched by assertions
	logic      strob2;
	logic      strob2b;

	// Command intake and classification
	fp_cmd_decode u_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.strob1    (strob1),
		.cmd_ready (cmd_ready),
		.pend_full (pend_full),
		.cur_phase (cur_phase),
		.cur_cmd   (cur_cmd)
	);

	// Phase sequencing
	fp_strobgen u_strobgen (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pend_full (pend_full),
		.cur_phase (cur_phase),
		.res_ready (res_ready),
		.strob1    (strob1),
		.strob1b   (strob1b),
		.strob2    (strob2),
		.strob2b   (strob2b),
		.res_valid (res_valid)
	);

	// Datapath
	fp_accum u_accum (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.clear     (clear),
		.strob1    (strob1),
		.strob2    (strob2),
		.cur_cmd   (cur_cmd),
		.cur_phase (cur_phase),
		.res       (res)
	);

endmodule

//--- verilog/fp_strobgen.sv
`timescale 1ns/1ps

module fp_strobgen (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              pend_full,	// es1
	input  fp_pkg::fp_phase_t cur_phase,
	input  logic              res_ready,	// Negated busy
	output logic              strob1,
	output logic              strob1b,
	output logic              strob2,
	output logic              strob2b,
	output logic              res_valid
);

	// ------------------------------------------------------------
	// Phase states
	// ------------------------------------------------------------
	localparam logic [2:0] S_GOT  = 3'd0;	// Idle, look for work
	localparam logic [2:0] S_GOTW = 3'd1;	// Wait for work
	localparam logic [2:0] S_ST1  = 3'd2;
	localparam logic [2:0] S_ST1B = 3'd3;	// Settle after strob1
	localparam logic [2:0] S_ST2  = 3'd4;
	localparam logic [2:0] S_ST2B = 3'd5;	// Settle after strob2
	localparam logic [2:0] S_PGOT = 3'd6;	// Result held

	logic [2:0] state;
	logic [2:0] state_nx;
	logic       busy;

	assign busy = ~res_ready;

	// Strobes decoded straight from the state
	assign strob1  = state == S_ST1;
	assign strob1b = state == S_ST1B;
	assign strob2  = state == S_ST2;
	assign strob2b = state == S_ST2B;

	// Load-state condition, minus busy
	assign res_valid = (state == S_PGOT)
		| ((state == S_ST1B) & cur_phase.one_step)
		| (state == S_ST2B);

	// ------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			S_GOT:
				state_nx = pend_full ? S_ST1 : S_GOTW;
			S_GOTW:
				if (pend_full)
					state_nx = S_ST1;
			S_ST1:
				state_nx = S_ST1B;
			S_ST1B:
				if (cur_phase.two_step)
					state_nx = S_ST2;
				else if (cur_phase.one_step & ~busy)
					state_nx = S_GOT;	// Result taken at once
				else
					state_nx = S_PGOT;
			S_ST2:
				state_nx = S_ST2B;
			S_ST2B:
				state_nx = busy ? S_PGOT : S_GOT;
			S_PGOT:
				if (~busy)
					state_nx = S_GOT;
			default:
				state_nx = S_GOT;	// Unused code
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			state <= S_GOT;
		else
			state <= state_nx;
	end

endmodule

//--- vlog.f
+incdir+verilog
verilog/fp_pkg.sv
verilog/fp_cmd_decode.sv
verilog/fp_strobgen.sv
verilog/fp_accum.sv
verilog/fp_seq_top.sv
tb/fp_seq_assert.sv
tb/fp_seq_tb.sv
